// File: design/mips_alu.sv
`timescale 1ns/1ps
`default_nettype none

module mips_alu (
	input  mips_pkg::alu_op_e op,
	input  logic [31:0]       a,
	input  logic [31:0]       b,
	input  logic [4:0]        shamt,
	output logic [31:0]       y,
	output logic              zero
);

	logic        lt_signed;
	logic        lt_unsigned;
	logic [31:0] sra_res;

	assign lt_signed   = ($signed(a) < $signed(b));
	assign lt_unsigned = (a < b);
	assign sra_res     = $signed(b) >>> shamt; // Sign fill from b[31]

	always_comb begin
		case (op)
			mips_pkg::alu_add: begin
				y = a + b; // No overflow trap
			end
			mips_pkg::alu_sub: begin
				y = a - b;
			end
			mips_pkg::alu_and: begin
				y = a & b;
			end
			mips_pkg::alu_or: begin
				y = a | b;
			end
			mips_pkg::alu_xor: begin
				y = a ^ b;
			end
			mips_pkg::alu_slt: begin
				y = {31'd0, lt_signed};
			end
			mips_pkg::alu_sltu: begin
				y = {31'd0, lt_unsigned};
			end
			mips_pkg::alu_sll: begin
				y = b << shamt; // Shifts act on rt
			end
			mips_pkg::alu_srl: begin
				y = b >> shamt;
			end
			mips_pkg::alu_sra: begin
				y = sra_res;
			end
			mips_pkg::alu_lui: begin
				y = {b[15:0], 16'h0000}; // Immediate into upper half
			end
			default: begin
				y = 32'd0;
			end
		endcase
	end

	assign zero = (y == 32'd0); // BEQ/BNE via SUB

endmodule

`default_nettype wire

// File: design/mips_cpu_harvard.sv
`timescale 1ns/1ps
`default_nettype none

module mips_cpu_harvard (
	input  logic        clk,
	input  logic        reset,
	output logic        active,
	output logic [31:0] register_v0,
	input  logic        clk_enable,
	output logic [31:0] instr_address,
	input  logic [31:0] instr_readdata,
	output logic [31:0] data_address,
	output logic        data_write,
	output logic        data_read,
	output logic [31:0] data_writedata,
	input  logic [31:0] data_readdata
);

	mips_pkg::instr_u instr;
	mips_pkg::ctrl_t  ctrl;
	logic             commit;
	logic [31:0]      pc;
	logic [31:0]      pc_plus4;
	logic [31:0]      rs_data;
	logic [31:0]      rt_data;
	logic [31:0]      imm_ext;
	logic [31:0]      alu_b;
	logic [4:0]       alu_shamt;
	logic [31:0]      alu_y;
	logic             zero;
	logic [4:0]       wa;
	logic [31:0]      wd;

	assign instr         = instr_readdata; // Decoded same cycle as fetch
	assign instr_address = pc;

	mips_run_ctrl u_run_ctrl (.clk(clk), .reset(reset), .clk_enable(clk_enable),
		.pc(pc), .active(active), .commit(commit));

	mips_decoder u_decoder (.instr(instr), .ctrl(ctrl));

	mips_pc_unit u_pc_unit (.clk(clk), .reset(reset), .commit(commit), .instr(instr),
		.ctrl(ctrl), .zero(zero), .rs_data(rs_data), .pc(pc), .pc_plus4(pc_plus4));

	mips_regfile u_regfile (.clk(clk), .reset(reset), .we(ctrl.reg_write && commit),
		.ra1(instr.r.rs), .ra2(instr.r.rt), .wa(wa), .wd(wd),
		.rd1(rs_data), .rd2(rt_data), .v0(register_v0));

	// Operand selection
	assign imm_ext   = ctrl.imm_zero_ext ? {16'd0, instr.i.imm}
		: {{16{instr.i.imm[15]}}, instr.i.imm};
	assign alu_b     = ctrl.src_imm ? imm_ext : rt_data;
	assign alu_shamt = ctrl.shift_imm ? instr.r.shamt : rs_data[4:0]; // Variable form from rs

	mips_alu u_alu (.op(ctrl.alu_op), .a(rs_data), .b(alu_b), .shamt(alu_shamt),
		.y(alu_y), .zero(zero));

	// Destination and writeback
	assign wa = ctrl.dst_ra ? 5'd31 : (ctrl.dst_rd ? instr.r.rd : instr.r.rt);
	assign wd = ctrl.link ? pc_plus4 : (ctrl.mem_to_reg ? data_readdata : alu_y);

	// Data port, strobes only on a committing cycle
	assign data_address   = alu_y;
	assign data_writedata = rt_data;
	assign data_write     = ctrl.mem_write && commit;
	assign data_read      = ctrl.mem_read && commit;

endmodule

`default_nettype wire

// File: design/mips_decoder.sv
`timescale 1ns/1ps
`default_nettype none
`include "mips_defs.svh"

module mips_decoder (
	input  mips_pkg::instr_u instr,
	output mips_pkg::ctrl_t  ctrl
);

	logic r_alu; // Known SPECIAL ALU funct
	logic i_alu; // Known immediate ALU op

	always_comb begin
		ctrl  = '0; // Unknown codes fall through as no-op
		r_alu = 1'b0;
		i_alu = 1'b0;
		case (instr.r.op)
			`MIPS_OP_SPECIAL: begin
				r_alu = 1'b1;
				case (instr.r.funct)
					`MIPS_FN_ADDU: ctrl.alu_op = mips_pkg::alu_add;
					`MIPS_FN_SUBU: ctrl.alu_op = mips_pkg::alu_sub;
					`MIPS_FN_AND:  ctrl.alu_op = mips_pkg::alu_and;
					`MIPS_FN_OR:   ctrl.alu_op = mips_pkg::alu_or;
					`MIPS_FN_XOR:  ctrl.alu_op = mips_pkg::alu_xor;
					`MIPS_FN_SLT:  ctrl.alu_op = mips_pkg::alu_slt;
					`MIPS_FN_SLTU: ctrl.alu_op = mips_pkg::alu_sltu;
					`MIPS_FN_SLL: begin
						ctrl.alu_op    = mips_pkg::alu_sll;
						ctrl.shift_imm = 1'b1;
					end
					`MIPS_FN_SRL: begin
						ctrl.alu_op    = mips_pkg::alu_srl;
						ctrl.shift_imm = 1'b1;
					end
					`MIPS_FN_SRA: begin
						ctrl.alu_op    = mips_pkg::alu_sra;
						ctrl.shift_imm = 1'b1;
					end
					`MIPS_FN_JR: begin
						r_alu         = 1'b0; // No writeback
						ctrl.jump_reg = 1'b1;
					end
					default: r_alu = 1'b0;
				endcase
				ctrl.reg_write = r_alu;
				ctrl.dst_rd    = r_alu;
			end
			`MIPS_OP_ADDIU: begin
				i_alu       = 1'b1;
				ctrl.alu_op = mips_pkg::alu_add;
			end
			`MIPS_OP_SLTI: begin
				i_alu       = 1'b1;
				ctrl.alu_op = mips_pkg::alu_slt;
			end
			`MIPS_OP_SLTIU: begin
				i_alu       = 1'b1; // Sign-extended, compared unsigned
				ctrl.alu_op = mips_pkg::alu_sltu;
			end
			`MIPS_OP_ANDI: begin
				i_alu             = 1'b1;
				ctrl.alu_op       = mips_pkg::alu_and;
				ctrl.imm_zero_ext = 1'b1;
			end
			`MIPS_OP_ORI: begin
				i_alu             = 1'b1;
				ctrl.alu_op       = mips_pkg::alu_or;
				ctrl.imm_zero_ext = 1'b1;
			end
			`MIPS_OP_XORI: begin
				i_alu             = 1'b1;
				ctrl.alu_op       = mips_pkg::alu_xor;
				ctrl.imm_zero_ext = 1'b1;
			end
			`MIPS_OP_LUI: begin
				i_alu       = 1'b1;
				ctrl.alu_op = mips_pkg::alu_lui;
			end
			`MIPS_OP_LW: begin
				i_alu           = 1'b1; // Address = rs + offset
				ctrl.mem_read   = 1'b1;
				ctrl.mem_to_reg = 1'b1;
			end
			`MIPS_OP_SW: begin
				ctrl.src_imm   = 1'b1;
				ctrl.mem_write = 1'b1;
			end
			`MIPS_OP_BEQ: begin
				ctrl.alu_op    = mips_pkg::alu_sub; // Zero flag compares rs, rt
				ctrl.branch_eq = 1'b1;
			end
			`MIPS_OP_BNE: begin
				ctrl.alu_op    = mips_pkg::alu_sub;
				ctrl.branch_ne = 1'b1;
			end
			`MIPS_OP_J: ctrl.jump = 1'b1;
			`MIPS_OP_JAL: begin
				ctrl.jump      = 1'b1;
				ctrl.link      = 1'b1;
				ctrl.dst_ra    = 1'b1;
				ctrl.reg_write = 1'b1;
			end
			default: ;
		endcase
		if (i_alu) begin
			ctrl.reg_write = 1'b1; // Dest is rt
			ctrl.src_imm   = 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: design/mips_defs.svh
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

`define MIPS_RESET_VECTOR 32'hBFC00000 // First fetch after reset
`define MIPS_HALT_ADDR    32'h00000000 // Fetch here ends the program
`define MIPS_NUM_REGS     32           // GPR count incl. $zero

// Primary opcodes, bits 31:26
`define MIPS_OP_SPECIAL 6'b000000 // R-type, see funct
`define MIPS_OP_J       6'b000010
`define MIPS_OP_JAL     6'b000011
`define MIPS_OP_BEQ     6'b000100
`define MIPS_OP_BNE     6'b000101
`define MIPS_OP_ADDIU   6'b001001
`define MIPS_OP_SLTI    6'b001010
`define MIPS_OP_SLTIU   6'b001011
`define MIPS_OP_ANDI    6'b001100
`define MIPS_OP_ORI     6'b001101
`define MIPS_OP_XORI    6'b001110
`define MIPS_OP_LUI     6'b001111
`define MIPS_OP_LW      6'b100011
`define MIPS_OP_SW      6'b101011

// SPECIAL funct codes, bits 5:0
`define MIPS_FN_SLL  6'b000000
`define MIPS_FN_SRL  6'b000010
`define MIPS_FN_SRA  6'b000011
`define MIPS_FN_JR   6'b001000
`define MIPS_FN_ADDU 6'b100001
`define MIPS_FN_SUBU 6'b100011
`define MIPS_FN_AND  6'b100100
`define MIPS_FN_OR   6'b100101
`define MIPS_FN_XOR  6'b100110
`define MIPS_FN_SLT  6'b101010
`define MIPS_FN_SLTU 6'b101011

`endif

// File: design/mips_pc_unit.sv
`timescale 1ns/1ps
`default_nettype none
`include "mips_defs.svh"

module mips_pc_unit (
	input  logic             clk,
	input  logic             reset,
	input  logic             commit,
	input  mips_pkg::instr_u instr,
	input  mips_pkg::ctrl_t  ctrl,
	input  logic             zero,
	input  logic [31:0]      rs_data,
	output logic [31:0]      pc,
	output logic [31:0]      pc_plus4
);

	logic [31:0] br_offset;
	logic [31:0] br_target;
	logic [31:0] j_target;
	logic        br_taken;
	logic [31:0] pc_next;

	assign pc_plus4 = pc + 32'd4; // Also the JAL link value

	// Word offset, sign-extended
	assign br_offset = {{14{instr.i.imm[15]}}, instr.i.imm, 2'b00};
	assign br_target = pc_plus4 + br_offset;
	assign j_target  = {pc_plus4[31:28], instr.j.target, 2'b00}; // Same 256 MB region

	assign br_taken = (ctrl.branch_eq && zero) || (ctrl.branch_ne && !zero);

	always_comb begin
		if (ctrl.jump_reg) begin
			pc_next = rs_data;
		end else if (ctrl.jump) begin
			pc_next = j_target;
		end else if (br_taken) begin
			pc_next = br_target;
		end else begin
			pc_next = pc_plus4; // No delay slot
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			pc <= `MIPS_RESET_VECTOR;
		end else if (commit) begin
			pc <= pc_next;
		end
	end

endmodule

`default_nettype wire

// File: design/mips_pkg.sv
`default_nettype none

package mips_pkg;

	// R format: register operands and funct
	typedef struct packed {
		logic [5:0] op;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt; // Shift amount for SLL/SRL/SRA
		logic [5:0] funct;
	} r_fmt_t;

	// I format: 16-bit immediate or branch offset
	typedef struct packed {
		logic [5:0]  op;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm;
	} i_fmt_t;

	// J format: word index inside 256 MB region
	typedef struct packed {
		logic [5:0]  op;
		logic [25:0] target;
	} j_fmt_t;

	// Same fetched word seen three ways
	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		j_fmt_t j;
	} instr_u;

	typedef enum logic [4:0] {
		alu_add  = 5'd0, // Also the idle value
		alu_sub  = 5'd1,
		alu_and  = 5'd2,
		alu_or   = 5'd3,
		alu_xor  = 5'd4,
		alu_slt  = 5'd5,
		alu_sltu = 5'd6,
		alu_sll  = 5'd7,
		alu_srl  = 5'd8,
		alu_sra  = 5'd9,
		alu_lui  = 5'd10
	} alu_op_e;

	typedef struct packed {
		logic    reg_write;    // GPR write this instruction
		logic    mem_read;     // LW
		logic    mem_write;    // SW
		logic    mem_to_reg;   // Writeback from data memory
		logic    dst_rd;       // Dest is rd, else rt
		logic    dst_ra;       // Dest is $31 for JAL
		logic    src_imm;      // ALU b from immediate
		logic    imm_zero_ext; // Logic immediates zero-extend
		logic    shift_imm;    // Shift amount from shamt field
		logic    branch_eq;
		logic    branch_ne;
		logic    jump;         // J / JAL
		logic    jump_reg;     // JR
		logic    link;         // Writeback of pc + 4
		alu_op_e alu_op;
	} ctrl_t;

endpackage

`default_nettype wire

// File: design/mips_regfile.sv
`timescale 1ns/1ps
`default_nettype none
`include "mips_defs.svh"

module mips_regfile (
	input  logic        clk,
	input  logic        reset,
	input  logic        we,
	input  logic [4:0]  ra1,
	input  logic [4:0]  ra2,
	input  logic [4:0]  wa,
	input  logic [31:0] wd,
	output logic [31:0] rd1,
	output logic [31:0] rd2,
	output logic [31:0] v0
);

	logic [31:0] regs [`MIPS_NUM_REGS];

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < `MIPS_NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (we && (wa != 5'd0)) begin
			regs[wa] <= wd; // $zero never written
		end
	end

	assign rd1 = (ra1 == 5'd0) ? 32'd0 : regs[ra1]; // Async read ports
	assign rd2 = (ra2 == 5'd0) ? 32'd0 : regs[ra2];
	assign v0  = regs[2]; // $v0 tap

endmodule

`default_nettype wire

// File: design/mips_run_ctrl.sv
`timescale 1ns/1ps
`default_nettype none
`include "mips_defs.svh"

module mips_run_ctrl (
	input  logic        clk,
	input  logic        reset,
	input  logic        clk_enable,
	input  logic [31:0] pc,
	output logic        active,
	output logic        commit
);

	localparam logic [1:0] st_idle   = 2'd0; // Settle cycle after reset
	localparam logic [1:0] st_run    = 2'd1;
	localparam logic [1:0] st_halted = 2'd2; // Left only by reset

	logic [1:0] state;
	logic [1:0] state_next;
	logic       at_halt;

	assign at_halt = (pc == `MIPS_HALT_ADDR); // Fetch of address zero

	always_comb begin
		state_next = state;
		case (state)
			st_idle:   state_next = st_run;
			st_run:    state_next = at_halt ? st_halted : st_run;
			st_halted: state_next = st_halted;
			default:   state_next = st_idle; // Unused code recovers
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= st_idle;
		end else if (clk_enable) begin
			state <= state_next; // Frozen while disabled
		end
	end

	assign active = (state == st_run);
	assign commit = active && clk_enable && !at_halt;

endmodule

`default_nettype wire

// File: flist.f
+incdir+design
+incdir+tb
design/mips_pkg.sv
design/mips_decoder.sv
design/mips_run_ctrl.sv
design/mips_pc_unit.sv
design/mips_regfile.sv
design/mips_alu.sv
design/mips_cpu_harvard.sv
tb/tb_mips_cpu.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the MIPS core testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log=sim.log

verilator --binary --timing --top-module tb_mips_cpu --Mdir "$build_dir" \
	-o tb_sim -f flist.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$build_dir/tb_sim" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Test failures found" "$log"; then
	echo "Simulation reported failures, see $log"
	exit 1
fi

echo "Simulation finished without failures"
exit 0

// File: tb/tb_mips_model.svh
`ifndef TB_MIPS_MODEL_SVH
`define TB_MIPS_MODEL_SVH

localparam logic [1:0] st_idle   = 2'd0; // Run state as the model sees it
localparam logic [1:0] st_run    = 2'd1;
localparam logic [1:0] st_halted = 2'd2;

logic [31:0] m_pc;
logic [31:0] m_regs [`MIPS_NUM_REGS];
logic [31:0] m_dmem [64]; // Same window as the data memory
logic [1:0]  m_state;

function automatic logic [31:0] rnd();
	rnd = $random(seed);
endfunction

function automatic logic [31:0] fill_word(input logic [5:0] idx);
	logic [7:0] a;
	a = {idx, 2'b00}; // Byte address inside the window
	fill_word = {a ^ 8'h5A, ~a, a, 8'hC3};
endfunction

function automatic logic [31:0] fetch_word(input logic [31:0] addr);
	logic [31:0] off;
	off = addr - `MIPS_RESET_VECTOR;
	fetch_word = (off[31:8] == 24'd0) ? imem[off[7:2]] : 32'd0; // Outside program reads NOP
endfunction

function automatic logic [31:0] enc_r(input logic [4:0] rs, input logic [4:0] rt,
	input logic [4:0] rd, input logic [4:0] sh, input logic [5:0] fn);
	enc_r = {`MIPS_OP_SPECIAL, rs, rt, rd, sh, fn};
endfunction

function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs,
	input logic [4:0] rt, input logic [15:0] imm);
	enc_i = {op, rs, rt, imm};
endfunction

function automatic logic [5:0] pick_fn(input logic [3:0] s);
	case (s)
		4'd1:    pick_fn = `MIPS_FN_SUBU;
		4'd2:    pick_fn = `MIPS_FN_AND;
		4'd3:    pick_fn = `MIPS_FN_OR;
		4'd4:    pick_fn = `MIPS_FN_XOR;
		4'd5:    pick_fn = `MIPS_FN_SLT;
		4'd6:    pick_fn = `MIPS_FN_SLTU;
		4'd7:    pick_fn = `MIPS_FN_SLL;
		4'd8:    pick_fn = `MIPS_FN_SRL;
		4'd9:    pick_fn = `MIPS_FN_SRA;
		default: pick_fn = `MIPS_FN_ADDU;
	endcase
endfunction

function automatic logic [5:0] pick_iop(input logic [2:0] s);
	case (s)
		3'd1:    pick_iop = `MIPS_OP_SLTI;
		3'd2:    pick_iop = `MIPS_OP_SLTIU;
		3'd3:    pick_iop = `MIPS_OP_ANDI;
		3'd4:    pick_iop = `MIPS_OP_ORI;
		3'd5:    pick_iop = `MIPS_OP_XORI;
		3'd6:    pick_iop = `MIPS_OP_LUI;
		default: pick_iop = `MIPS_OP_ADDIU;
	endcase
endfunction

// One random instruction at slot k; flow targets stay in (k, last]
function automatic logic [31:0] rand_instr(input int k, input int last);
	logic [31:0] r;
	logic [31:0] s;
	logic [31:0] tgt;
	logic [4:0]  dst;
	int          t;
	int          off;
	r = rnd();
	s = rnd();
	dst = r[31] ? 5'd2 : r[30:26]; // Lean on $v0 so results show outside
	t = k + 1 + (int'(s[11:0]) % (last - k));
	off = t - k - 1;
	tgt = `MIPS_RESET_VECTOR + 32'(t * 4);
	case (r[3:0])
		4'd0, 4'd1, 4'd2, 4'd3, 4'd4:
			rand_instr = enc_r(r[8:4], r[13:9], dst, r[18:14], pick_fn(r[22:19]));
		4'd5, 4'd6, 4'd7, 4'd8:
			rand_instr = enc_i(pick_iop(r[25:23]), r[8:4], dst, s[31:16]);
		4'd9, 4'd10:
			rand_instr = enc_i(`MIPS_OP_LW, 5'd0, dst, {8'd0, s[21:16], 2'b00});
		4'd11:
			rand_instr = enc_i(`MIPS_OP_SW, 5'd0, r[13:9], {8'd0, s[21:16], 2'b00});
		4'd12, 4'd13: // Small register set so both outcomes occur
			rand_instr = enc_i(r[0] ? `MIPS_OP_BNE : `MIPS_OP_BEQ, {3'd0, r[5:4]},
				{3'd0, r[7:6]}, off[15:0]);
		4'd14:   rand_instr = {`MIPS_OP_J, tgt[27:2]};
		default: rand_instr = {`MIPS_OP_JAL, tgt[27:2]};
	endcase
endfunction

task automatic gen_program(input int len);
	for (int k = 0; k < 64; k++) begin
		imem[k] = 32'd0;
	end
	for (int k = 0; k < len - 2; k++) begin
		imem[k] = rand_instr(k, len - 2);
	end
	imem[len - 2] = enc_r(5'd0, 5'd0, 5'd25, 5'd0, `MIPS_FN_ADDU); // Clear $25
	imem[len - 1] = enc_r(5'd25, 5'd0, 5'd0, 5'd0, `MIPS_FN_JR);  // Jump to zero ends run
endtask

task automatic model_reset();
	m_pc = `MIPS_RESET_VECTOR;
	m_state = st_idle;
	for (int i = 0; i < `MIPS_NUM_REGS; i++) begin
		m_regs[i] = 32'd0;
	end
	for (int i = 0; i < 64; i++) begin
		m_dmem[i] = fill_word(6'(i));
	end
endtask

// Executes one instruction and reports the memory access it makes
task automatic model_step(input logic [31:0] w, output logic we, output logic re,
	output logic [31:0] addr, output logic [31:0] wdata);
	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] simm;
	logic [31:0] zimm;
	logic [31:0] res;
	logic [31:0] nxt;
	logic [4:0]  dst;
	logic        wr;
	a = m_regs[w[25:21]];
	b = m_regs[w[20:16]];
	simm = {{16{w[15]}}, w[15:0]};
	zimm = {16'd0, w[15:0]};
	nxt = m_pc + 32'd4;
	res = 32'd0;
	dst = w[20:16]; // rt unless told otherwise
	wr = 1'b1;
	we = 1'b0;
	re = 1'b0;
	addr = a + simm;
	wdata = b;
	case (w[31:26])
		`MIPS_OP_SPECIAL: begin
			dst = w[15:11];
			case (w[5:0])
				`MIPS_FN_ADDU: res = a + b;
				`MIPS_FN_SUBU: res = a - b;
				`MIPS_FN_AND:  res = a & b;
				`MIPS_FN_OR:   res = a | b;
				`MIPS_FN_XOR:  res = a ^ b;
				`MIPS_FN_SLT:  res = {31'd0, $signed(a) < $signed(b)};
				`MIPS_FN_SLTU: res = {31'd0, a < b};
				`MIPS_FN_SLL:  res = b << w[10:6];
				`MIPS_FN_SRL:  res = b >> w[10:6];
				`MIPS_FN_SRA:  res = $signed(b) >>> w[10:6];
				`MIPS_FN_JR: begin
					wr = 1'b0;
					nxt = a;
				end
				default: wr = 1'b0;
			endcase
		end
		`MIPS_OP_ADDIU: res = a + simm;
		`MIPS_OP_SLTI:  res = {31'd0, $signed(a) < $signed(simm)};
		`MIPS_OP_SLTIU: res = {31'd0, a < simm};
		`MIPS_OP_ANDI:  res = a & zimm;
		`MIPS_OP_ORI:   res = a | zimm;
		`MIPS_OP_XORI:  res = a ^ zimm;
		`MIPS_OP_LUI:   res = {w[15:0], 16'd0};
		`MIPS_OP_LW: begin
			re = 1'b1;
			res = m_dmem[addr[7:2]];
		end
		`MIPS_OP_SW: begin
			wr = 1'b0;
			we = 1'b1;
			m_dmem[addr[7:2]] = b;
		end
		`MIPS_OP_BEQ: begin
			wr = 1'b0;
			nxt = (a == b) ? m_pc + 32'd4 + (simm << 2) : nxt;
		end
		`MIPS_OP_BNE: begin
			wr = 1'b0;
			nxt = (a != b) ? m_pc + 32'd4 + (simm << 2) : nxt;
		end
		`MIPS_OP_J: begin
			wr = 1'b0;
			nxt = {nxt[31:28], w[25:0], 2'b00};
		end
		`MIPS_OP_JAL: begin
			res = m_pc + 32'd4; // Return address, no delay slot
			dst = 5'd31;
			nxt = {nxt[31:28], w[25:0], 2'b00};
		end
		default: wr = 1'b0;
	endcase
	if (wr && (dst != 5'd0)) begin
		m_regs[dst] = res;
	end
	m_pc = nxt;
endtask

`endif

// File: tb/tb_mips_cpu.sv
`timescale 1ns/1ps
`default_nettype none
`include "mips_defs.svh"

module tb_mips_cpu;

	localparam int num_progs    = 12;
	localparam int prog_len     = 40; // Words per program, at most 64
	localparam int stall_factor = 8;  // Worst clock-enable slowdown allowed
	localparam int clk_period   = 20;
	localparam int watchdog_ns  = num_progs * (prog_len + 8) * stall_factor * clk_period;

	logic        clk;
	logic        reset;
	logic        clk_enable;
	logic        active;
	logic [31:0] register_v0;
	logic [31:0] instr_address;
	logic [31:0] instr_readdata;
	logic [31:0] instr_off;
	logic [31:0] data_address;
	logic        data_write;
	logic        data_read;
	logic [31:0] data_writedata;
	logic [31:0] data_readdata;
	logic [31:0] imem [64]; // Program store at the reset vector
	logic [31:0] dmem [64]; // 64-word data window from address zero
	integer      seed;
	int          errors;
	int          checks;

	`include "tb_mips_model.svh"

	mips_cpu_harvard u_dut (.clk(clk), .reset(reset), .active(active),
		.register_v0(register_v0), .clk_enable(clk_enable),
		.instr_address(instr_address), .instr_readdata(instr_readdata),
		.data_address(data_address), .data_write(data_write), .data_read(data_read),
		.data_writedata(data_writedata), .data_readdata(data_readdata));

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	assign instr_off      = instr_address - `MIPS_RESET_VECTOR;
	assign instr_readdata = (instr_off[31:8] == 24'd0) ? imem[instr_off[7:2]] : 32'd0;
	assign data_readdata  = dmem[data_address[7:2]]; // Combinational read

	always @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 64; i++) begin
				dmem[i] <= fill_word(6'(i)); // Fresh contents for every program
			end
		end else if (data_write && clk_enable) begin
			dmem[data_address[7:2]] <= data_writedata;
		end
	end

	task automatic expect_word(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL t=%0t %s: got %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic expect_bit(input string what, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL t=%0t %s: got %b, expected %b", $time, what, got, exp);
		end
	endtask

	// Compare one cycle ahead of its edge, then advance the model
	task automatic check_cycle();
		logic        we;
		logic        re;
		logic [31:0] addr;
		logic [31:0] wdata;
		we = 1'b0;
		re = 1'b0;
		addr = 32'd0;
		wdata = 32'd0;
		expect_word("instr_address", instr_address, m_pc);
		expect_word("register_v0", register_v0, m_regs[2]);
		expect_bit("active", active, m_state == st_run);
		if (clk_enable) begin
			case (m_state)
				st_idle: m_state = st_run; // Settle edge, nothing commits
				st_run: begin
					if (m_pc == `MIPS_HALT_ADDR) begin
						m_state = st_halted;
					end else begin
						model_step(fetch_word(m_pc), we, re, addr, wdata);
					end
				end
				default: ;
			endcase
		end
		expect_bit("data_write", data_write, we);
		expect_bit("data_read", data_read, re);
		if (we || re) begin
			expect_word("data_address", data_address, addr);
		end
		if (we) begin
			expect_word("data_writedata", data_writedata, wdata);
		end
	endtask

	initial begin
		#(watchdog_ns);
		$display("Timeout: run still going after %0d ns, core never reached halt", watchdog_ns);
		$display("Test failures found");
		$finish;
	end

	initial begin
		logic [31:0] r;
		seed = 32'h10ad5fd5;
		errors = 0;
		checks = 0;
		reset = 1'b1;
		clk_enable = 1'b0;
		for (int p = 0; p < num_progs; p++) begin
			@(negedge clk);
			reset = 1'b1;
			clk_enable = 1'b0;
			gen_program(prog_len);
			model_reset();
			repeat (2) @(negedge clk);
			reset = 1'b0;
			#1;
			expect_bit("active after reset", active, 1'b0);
			expect_bit("data_write after reset", data_write, 1'b0);
			expect_bit("data_read after reset", data_read, 1'b0);
			expect_word("instr_address after reset", instr_address, `MIPS_RESET_VECTOR);
			while (m_state != st_halted) begin
				@(negedge clk);
				r = rnd();
				clk_enable = (r[1:0] != 2'b00); // Roughly one stall in four
				#1;
				check_cycle();
			end
			@(negedge clk);
			#1;
			expect_bit("active at halt", active, 1'b0);
			expect_word("register_v0 at halt", register_v0, m_regs[2]);
			expect_word("instr_address at halt", instr_address, `MIPS_HALT_ADDR);
		end
		$display("Programs: %0d, checks: %0d, errors: %0d", num_progs, checks, errors);
		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

`default_nettype wire
